// File: include/kvs_cfg.svh
`ifndef KVS_CFG_SVH
`define KVS_CFG_SVH

// key and value geometry
`define KVS_KEY_W           96
`define KVS_VAL_W           32
`define KVS_HASH_W          32

// bucket address, low bits of the hash
`define KVS_ADDR_W          30

// one bucket is four 16-byte slots
`define KVS_SLOTS           4
`define KVS_SLOT_W          128
`define KVS_BUCKET_W        512
`define KVS_STRB_W          64

// queue depth is 2**6 entries
`define KVS_FIFO_DEPTH_LOG2 6

// request opcodes
`define KVS_OP_SET          4'h1
`define KVS_OP_GET          4'h0

// memory controller commands
`define KVS_CMD_READ        3'b001
`define KVS_CMD_WRITE       3'b000

`endif

// File: hdl/kvs_pkg.sv
`include "kvs_cfg.svh"

package kvs_pkg;

	// request as presented on the input side
	typedef struct packed {
		logic [3:0]             op;
		logic [`KVS_HASH_W-1:0] hash;
		logic [`KVS_KEY_W-1:0]  key;
		logic [`KVS_VAL_W-1:0]  value;
	} kvs_req_t;

	// one table entry, key in the upper bits
	typedef struct packed {
		logic [`KVS_KEY_W-1:0] key;
		logic [`KVS_VAL_W-1:0] value;
	} kvs_slot_t;

	// slot 0 sits in the low 128 bits
	typedef kvs_slot_t [`KVS_SLOTS-1:0] kvs_bucket_t;

	typedef struct packed {
		logic [`KVS_ADDR_W-1:0] addr;
		kvs_bucket_t            data;
		logic [`KVS_STRB_W-1:0] strb;
	} kvs_wr_cmd_t;

	typedef struct packed {
		logic [`KVS_ADDR_W-1:0] addr;
	} kvs_rd_cmd_t;

	// GET waiting for its bucket to come back
	typedef struct packed {
		logic [`KVS_ADDR_W-1:0] addr;
		logic [`KVS_KEY_W-1:0]  key;
		logic [`KVS_VAL_W-1:0]  value;
	} kvs_pending_get_t;

	typedef enum logic [1:0] {
		ARB_RD = 2'b01,
		ARB_WR = 2'b10
	} kvs_arb_e;

endpackage

// File: hdl/kvs_sync_fifo.sv
`timescale 1ns/1ps
`include "kvs_cfg.svh"

module kvs_sync_fifo #(
	parameter type payload_t = logic
) (
	input  logic     ui_mig_clk,
	input  logic     ui_mig_rst,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty,
	output logic     full
);

	localparam int addr_w = `KVS_FIFO_DEPTH_LOG2;
	localparam int depth  = 1 << addr_w;

	payload_t mem [depth];

	// extra msb tells a full ring from an empty one
	logic [addr_w:0] wr_ptr;
	logic [addr_w:0] rd_ptr;

	// ----------------------------------------
	// pointers
	// ----------------------------------------
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge ui_mig_clk) begin
		if (push) begin
			mem[wr_ptr[addr_w-1:0]] <= push_data;
		end
	end

	// head is visible without a pop
	assign pop_data = mem[rd_ptr[addr_w-1:0]];

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
		(wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

	// ----------------------------------------
	// producer and consumer must respect levels
	// ----------------------------------------
	a_no_overflow: assert property (
		@(posedge ui_mig_clk) disable iff (ui_mig_rst) push |-> !full
	);

	a_no_underflow: assert property (
		@(posedge ui_mig_clk) disable iff (ui_mig_rst) pop |-> !empty
	);

endmodule

// File: hdl/kvs_req_intake.sv
`timescale 1ns/1ps
`include "kvs_cfg.svh"

module kvs_req_intake (
	input  logic                      ui_mig_clk,
	input  logic                      ui_mig_rst,
	input  logic                      in_valid,
	input  kvs_pkg::kvs_req_t         in_req,
	input  kvs_pkg::kvs_wr_cmd_t      up_head,
	input  logic                      up_empty,
	output logic                      up_pop,
	output logic                      wr_push,
	output kvs_pkg::kvs_wr_cmd_t      wr_data,
	output logic                      rd_push,
	output kvs_pkg::kvs_rd_cmd_t      rd_data,
	output logic                      get_push,
	output kvs_pkg::kvs_pending_get_t get_data
);

	localparam int         slot_bytes = `KVS_STRB_W / `KVS_SLOTS;
	localparam logic [1:0] prbs_seed  = 2'b01;

	logic [1:0]             prbs_q;
	logic                   is_set;
	logic                   is_get;
	logic [`KVS_ADDR_W-1:0] bucket_addr;
	kvs_pkg::kvs_slot_t     new_slot;
	kvs_pkg::kvs_wr_cmd_t   set_cmd;

	// ----------------------------------------
	// slot choice
	// ----------------------------------------

	// x^2 + x + 1, steps every cycle
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			prbs_q <= prbs_seed;
		end else begin
			prbs_q <= {prbs_q[0], prbs_q[1] ^ prbs_q[0]};
		end
	end

	// ----------------------------------------
	// decode
	// ----------------------------------------
	assign is_set = in_valid && (in_req.op == `KVS_OP_SET);
	assign is_get = in_valid && (in_req.op == `KVS_OP_GET);

	assign bucket_addr    = in_req.hash[`KVS_ADDR_W-1:0];
	assign new_slot.key   = in_req.key;
	assign new_slot.value = in_req.value;

	// slot placed at its lane, strobe over its 16 bytes
	always_comb begin
		set_cmd = '0;
		set_cmd.addr = bucket_addr;
		set_cmd.data[prbs_q] = new_slot;
		set_cmd.strb[prbs_q * slot_bytes +: slot_bytes] = '1;
	end

	// ----------------------------------------
	// write queue, SET first
	// ----------------------------------------

	// refresh write-backs only use cycles with no SET
	assign up_pop  = !is_set && !up_empty;
	assign wr_push = is_set || up_pop;
	assign wr_data = is_set ? set_cmd : up_head;

	// ----------------------------------------
	// read and pending GET queues
	// ----------------------------------------
	assign rd_push      = is_get;
	assign rd_data.addr = bucket_addr;

	assign get_push       = is_get;
	assign get_data.addr  = bucket_addr;
	assign get_data.key   = in_req.key;
	assign get_data.value = in_req.value;

endmodule

// File: hdl/kvs_cmd_arbiter.sv
`timescale 1ns/1ps
`include "kvs_cfg.svh"

module kvs_cmd_arbiter (
	input  logic                     ui_mig_clk,
	input  logic                     ui_mig_rst,
	input  logic                     init_calib_complete,
	input  kvs_pkg::kvs_wr_cmd_t     wr_head,
	input  logic                     wr_empty,
	input  kvs_pkg::kvs_rd_cmd_t     rd_head,
	input  logic                     rd_empty,
	input  logic                     app_rdy,
	input  logic                     app_wdf_rdy,
	output logic                     wr_pop,
	output logic                     rd_pop,
	output logic                     app_en,
	output logic [2:0]               app_cmd,
	output logic [`KVS_ADDR_W-1:0]   app_addr,
	output logic                     app_wdf_wren,
	output logic                     app_wdf_end,
	output logic [`KVS_BUCKET_W-1:0] app_wdf_data,
	output logic [`KVS_STRB_W-1:0]   app_wdf_mask
);

	kvs_pkg::kvs_arb_e arb_q;
	logic              wr_ok;
	logic              rd_ok;
	logic              wr_sel;
	logic              rd_sel;

	// write needs the data path ready as well
	assign wr_ok = init_calib_complete && !wr_empty && app_wdf_rdy;
	assign rd_ok = init_calib_complete && !rd_empty;

	// ----------------------------------------
	// selection
	// ----------------------------------------
	always_comb begin
		wr_sel = wr_ok;
		rd_sel = rd_ok;
		if (wr_ok && rd_ok) begin
			wr_sel = (arb_q == kvs_pkg::ARB_WR);
			rd_sel = (arb_q == kvs_pkg::ARB_RD);
		end
	end

	// flips only when a contested command is taken
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			arb_q <= kvs_pkg::ARB_RD;
		end else if (wr_ok && rd_ok && app_rdy) begin
			arb_q <= (arb_q == kvs_pkg::ARB_RD) ? kvs_pkg::ARB_WR : kvs_pkg::ARB_RD;
		end
	end

	// ----------------------------------------
	// memory user interface
	// ----------------------------------------
	assign app_en   = wr_sel || rd_sel;
	assign app_cmd  = wr_sel ? `KVS_CMD_WRITE : `KVS_CMD_READ;
	assign app_addr = wr_sel ? wr_head.addr : rd_head.addr;

	// single-beat bucket with its data alongside the command
	assign app_wdf_wren = wr_sel && app_rdy;
	assign app_wdf_end  = app_wdf_wren;
	assign app_wdf_data = wr_head.data;
	assign app_wdf_mask = ~wr_head.strb;

	assign wr_pop = wr_sel && app_rdy;
	assign rd_pop = rd_sel && app_rdy;

endmodule

// File: hdl/kvs_bucket_lookup.sv
`timescale 1ns/1ps
`include "kvs_cfg.svh"

module kvs_bucket_lookup (
	input  logic                      ui_mig_clk,
	input  logic                      ui_mig_rst,
	input  logic                      app_rd_data_valid,
	input  logic [`KVS_BUCKET_W-1:0]  app_rd_data,
	input  kvs_pkg::kvs_pending_get_t get_head,
	output logic                      get_pop,
	output logic                      up_push,
	output kvs_pkg::kvs_wr_cmd_t      up_data,
	output logic                      out_valid,
	output logic [3:0]                out_flag,
	output logic [`KVS_VAL_W-1:0]     out_value
);

	localparam int slot_bytes = `KVS_STRB_W / `KVS_SLOTS;

	// stage 1
	logic                      s1_valid;
	kvs_pkg::kvs_bucket_t      s1_bucket;
	kvs_pkg::kvs_pending_get_t s1_get;
	logic [`KVS_SLOTS-1:0]     match;
	logic [`KVS_VAL_W-1:0]     match_value;

	// stage 2
	logic                      s2_valid;
	logic [`KVS_SLOTS-1:0]     s2_match;
	logic [`KVS_VAL_W-1:0]     s2_value;
	kvs_pkg::kvs_bucket_t      s2_bucket;
	kvs_pkg::kvs_pending_get_t s2_get;
	kvs_pkg::kvs_wr_cmd_t      refresh_cmd;

	// stage 3
	logic                      s3_valid;
	logic                      s3_hit;
	logic [`KVS_VAL_W-1:0]     s3_value;
	kvs_pkg::kvs_wr_cmd_t      s3_cmd;

	// pending GET leaves its queue with its bucket
	assign get_pop = app_rd_data_valid;

	// ----------------------------------------
	// valid pipe
	// ----------------------------------------
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end else begin
			s1_valid <= app_rd_data_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
		end
	end

	// ----------------------------------------
	// stage 2 compare
	// ----------------------------------------
	always_comb begin
		match_value = '0;
		for (int i = 0; i < `KVS_SLOTS; i++) begin
			match[i] = (s1_bucket[i].key == s1_get.key);
			if (match[i]) begin
				match_value = match_value | s1_bucket[i].value;
			end
		end
	end

	// ----------------------------------------
	// stage 3 refresh bucket
	// ----------------------------------------

	// hit slot takes the GET's key and value
	always_comb begin
		refresh_cmd.addr = s2_get.addr;
		refresh_cmd.data = s2_bucket;
		refresh_cmd.strb = '0;
		for (int i = 0; i < `KVS_SLOTS; i++) begin
			if (s2_match[i]) begin
				refresh_cmd.data[i].key   = s2_get.key;
				refresh_cmd.data[i].value = s2_get.value;
				refresh_cmd.strb[i * slot_bytes +: slot_bytes] = '1;
			end
		end
	end

	always_ff @(posedge ui_mig_clk) begin
		if (app_rd_data_valid) begin
			s1_bucket <= app_rd_data;
			s1_get    <= get_head;
		end
		s2_match  <= match;
		s2_value  <= match_value;
		s2_bucket <= s1_bucket;
		s2_get    <= s1_get;
		s3_hit    <= |s2_match;
		s3_value  <= s2_value;
		s3_cmd    <= refresh_cmd;
	end

	// ----------------------------------------
	// results
	// ----------------------------------------
	assign out_valid = s3_valid;
	assign out_flag  = s3_hit ? 4'h1 : 4'h0;

	// zero on a miss, no slot contributes
	assign out_value = s3_value;

	assign up_push = s3_valid && s3_hit;
	assign up_data = s3_cmd;

	// one key per bucket, the table never holds duplicates
	a_match_onehot: assert property (
		@(posedge ui_mig_clk) disable iff (ui_mig_rst) s2_valid |-> $onehot0(s2_match)
	);

endmodule

// File: hdl/kvs_cache_top.sv
`timescale 1ns/1ps
`include "kvs_cfg.svh"

module kvs_cache_top (
	input  logic                     ui_mig_clk,
	input  logic                     ui_mig_rst,
	input  logic                     in_valid,
	input  kvs_pkg::kvs_req_t        in_req,
	input  logic                     init_calib_complete,
	input  logic                     app_rdy,
	input  logic                     app_wdf_rdy,
	input  logic [`KVS_BUCKET_W-1:0] app_rd_data,
	input  logic                     app_rd_data_valid,
	output logic                     app_en,
	output logic [2:0]               app_cmd,
	output logic [`KVS_ADDR_W-1:0]   app_addr,
	output logic                     app_wdf_wren,
	output logic                     app_wdf_end,
	output logic [`KVS_BUCKET_W-1:0] app_wdf_data,
	output logic [`KVS_STRB_W-1:0]   app_wdf_mask,
	output logic                     out_valid,
	output logic [3:0]               out_flag,
	output logic [`KVS_VAL_W-1:0]    out_value
);

	// write queue
	logic                 wr_push;
	logic                 wr_pop;
	logic                 wr_empty;
	kvs_pkg::kvs_wr_cmd_t wr_data;
	kvs_pkg::kvs_wr_cmd_t wr_head;

	// read queue
	logic                 rd_push;
	logic                 rd_pop;
	logic                 rd_empty;
	kvs_pkg::kvs_rd_cmd_t rd_data;
	kvs_pkg::kvs_rd_cmd_t rd_head;

	// pending GETs
	logic                      get_push;
	logic                      get_pop;
	kvs_pkg::kvs_pending_get_t get_data;
	kvs_pkg::kvs_pending_get_t get_head;

	// refresh write-backs
	logic                 up_push;
	logic                 up_pop;
	logic                 up_empty;
	kvs_pkg::kvs_wr_cmd_t up_data;
	kvs_pkg::kvs_wr_cmd_t up_head;

	kvs_req_intake i_kvs_req_intake (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.up_head    (up_head),
		.up_empty   (up_empty),
		.up_pop     (up_pop),
		.wr_push    (wr_push),
		.wr_data    (wr_data),
		.rd_push    (rd_push),
		.rd_data    (rd_data),
		.get_push   (get_push),
		.get_data   (get_data)
	);

	// ----------------------------------------
	// queues
	// ----------------------------------------
	kvs_sync_fifo #(.payload_t(kvs_pkg::kvs_wr_cmd_t)) i_wr_fifo (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (wr_push),
		.push_data  (wr_data),
		.pop        (wr_pop),
		.pop_data   (wr_head),
		.empty      (wr_empty),
		.full       ()
	);

	kvs_sync_fifo #(.payload_t(kvs_pkg::kvs_rd_cmd_t)) i_rd_fifo (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (rd_push),
		.push_data  (rd_data),
		.pop        (rd_pop),
		.pop_data   (rd_head),
		.empty      (rd_empty),
		.full       ()
	);

	kvs_sync_fifo #(.payload_t(kvs_pkg::kvs_pending_get_t)) i_get_fifo (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (get_push),
		.push_data  (get_data),
		.pop        (get_pop),
		.pop_data   (get_head),
		.empty      (),
		.full       ()
	);

	kvs_sync_fifo #(.payload_t(kvs_pkg::kvs_wr_cmd_t)) i_up_fifo (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (up_push),
		.push_data  (up_data),
		.pop        (up_pop),
		.pop_data   (up_head),
		.empty      (up_empty),
		.full       ()
	);

	// ----------------------------------------
	// memory side
	// ----------------------------------------
	kvs_cmd_arbiter i_kvs_cmd_arbiter (
		.ui_mig_clk          (ui_mig_clk),
		.ui_mig_rst          (ui_mig_rst),
		.init_calib_complete (init_calib_complete),
		.wr_head             (wr_head),
		.wr_empty            (wr_empty),
		.rd_head             (rd_head),
		.rd_empty            (rd_empty),
		.app_rdy             (app_rdy),
		.app_wdf_rdy         (app_wdf_rdy),
		.wr_pop              (wr_pop),
		.rd_pop              (rd_pop),
		.app_en              (app_en),
		.app_cmd             (app_cmd),
		.app_addr            (app_addr),
		.app_wdf_wren        (app_wdf_wren),
		.app_wdf_end         (app_wdf_end),
		.app_wdf_data        (app_wdf_data),
		.app_wdf_mask        (app_wdf_mask)
	);

	kvs_bucket_lookup i_kvs_bucket_lookup (
		.ui_mig_clk        (ui_mig_clk),
		.ui_mig_rst        (ui_mig_rst),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.get_head          (get_head),
		.get_pop           (get_pop),
		.up_push           (up_push),
		.up_data           (up_data),
		.out_valid         (out_valid),
		.out_flag          (out_flag),
		.out_value         (out_value)
	);

endmodule

// File: tb/kvs_mem_model.sv
`timescale 1ns/1ps
`include "kvs_cfg.svh"

module kvs_mem_model (
	input  logic                     ui_mig_clk,
	input  logic                     ui_mig_rst,
	input  logic                     app_en,
	input  logic [2:0]               app_cmd,
	input  logic [`KVS_ADDR_W-1:0]   app_addr,
	input  logic                     app_wdf_wren,
	input  logic                     app_wdf_end,
	input  logic [`KVS_BUCKET_W-1:0] app_wdf_data,
	input  logic [`KVS_STRB_W-1:0]   app_wdf_mask,
	output logic                     init_calib_complete,
	output logic                     app_rdy,
	output logic                     app_wdf_rdy,
	output logic [`KVS_BUCKET_W-1:0] app_rd_data,
	output logic                     app_rd_data_valid,
	output int                       wr_count
);

	localparam int buckets      = 256;
	localparam int calib_cycles = 8;

	logic [`KVS_BUCKET_W-1:0] mem [buckets];
	logic [`KVS_BUCKET_W-1:0] rd_q [$];
	int                       due_q [$];

	logic                     calib_q    = 1'b0;
	logic                     rdy_q      = 1'b0;
	logic                     wdf_rdy_q  = 1'b0;
	logic                     valid_q    = 1'b0;
	logic [`KVS_BUCKET_W-1:0] data_q     = '0;
	int                       wr_count_q = 0;
	int                       calib_cnt  = 0;
	int                       cycle      = 0;
	int                       last_due   = 0;
	int                       due        = 0;

	assign init_calib_complete = calib_q;
	assign app_rdy             = rdy_q;
	assign app_wdf_rdy         = wdf_rdy_q;
	assign app_rd_data         = data_q;
	assign app_rd_data_valid   = valid_q;
	assign wr_count            = wr_count_q;

	// mask bit high keeps the stored byte
	function automatic logic [`KVS_BUCKET_W-1:0] merge_bytes(
		input logic [`KVS_BUCKET_W-1:0] old_data,
		input logic [`KVS_BUCKET_W-1:0] new_data,
		input logic [`KVS_STRB_W-1:0]   mask
	);
		logic [`KVS_BUCKET_W-1:0] merged;
		merged = old_data;
		for (int i = 0; i < `KVS_STRB_W; i++) begin
			if (!mask[i]) begin
				merged[i*8 +: 8] = new_data[i*8 +: 8];
			end
		end
		return merged;
	endfunction

	// every slot gets a key no table entry uses
	initial begin
		for (int b = 0; b < buckets; b++) begin
			for (int s = 0; s < `KVS_SLOTS; s++) begin
				mem[b][s*`KVS_SLOT_W +: `KVS_SLOT_W] =
					{32'hfeed_0000 | 32'(b), 64'(s), 32'(b * 4 + s)};
			end
		end
	end

	always @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			calib_q    <= 1'b0;
			rdy_q      <= 1'b0;
			wdf_rdy_q  <= 1'b0;
			valid_q    <= 1'b0;
			data_q     <= '0;
			wr_count_q <= 0;
			calib_cnt  <= 0;
			cycle = 0;
			last_due = 0;
			due_q.delete();
			rd_q.delete();
		end else begin
			cycle = cycle + 1;
			if (calib_cnt < calib_cycles) begin
				calib_cnt <= calib_cnt + 1;
			end
			calib_q   <= (calib_cnt == calib_cycles);
			wdf_rdy_q <= 1'b1;
			// drops about one cycle in four
			rdy_q <= ($urandom % 4) != 0;

			if (app_en && rdy_q) begin
				if (app_cmd == `KVS_CMD_WRITE && app_wdf_wren && app_wdf_end) begin
					mem[app_addr[7:0]] <= merge_bytes(mem[app_addr[7:0]], app_wdf_data,
						app_wdf_mask);
					wr_count_q <= wr_count_q + 1;
				end else if (app_cmd == `KVS_CMD_READ) begin
					// 2 to 8 cycles, never ahead of an older read
					due = cycle + 2 + int'($urandom % 7);
					if (due <= last_due) begin
						due = last_due + 1;
					end
					last_due = due;
					due_q.push_back(due);
					rd_q.push_back(mem[app_addr[7:0]]);
				end
			end

			valid_q <= 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				valid_q <= 1'b1;
				data_q  <= rd_q.pop_front();
				void'(due_q.pop_front());
			end
		end
	end

endmodule

// File: tb/tb_kvs_cache_top.sv
`timescale 1ns/1ps
`include "kvs_cfg.svh"

module tb_kvs_cache_top;

	localparam int num_steps   = 12;
	localparam int result_wait = 200;
	localparam int write_wait  = 200;
	localparam int slot_bytes  = 16;

	localparam logic [`KVS_KEY_W-1:0] key_a = 96'h0123_4567_89ab_cdef_0000_0001;
	localparam logic [`KVS_KEY_W-1:0] key_b = 96'h0123_4567_89ab_cdef_0000_0002;
	localparam logic [`KVS_KEY_W-1:0] key_c = 96'h7e57_0000_1111_2222_3333_0003;
	localparam logic [`KVS_KEY_W-1:0] key_d = 96'h4444_5555_6666_7777_8888_0004;
	localparam logic [`KVS_KEY_W-1:0] key_e = 96'h9999_aaaa_bbbb_cccc_dddd_0005;

	// request plus the result a GET must give
	typedef struct packed {
		kvs_pkg::kvs_req_t     req;
		logic [3:0]            exp_flag;
		logic [`KVS_VAL_W-1:0] exp_value;
	} step_t;

	logic              ui_mig_clk = 1'b0;
	logic              ui_mig_rst = 1'b1;
	logic              in_valid   = 1'b0;
	kvs_pkg::kvs_req_t in_req     = '0;

	logic                     init_calib_complete;
	logic                     app_rdy;
	logic                     app_wdf_rdy;
	logic [`KVS_BUCKET_W-1:0] app_rd_data;
	logic                     app_rd_data_valid;
	logic                     app_en;
	logic [2:0]               app_cmd;
	logic [`KVS_ADDR_W-1:0]   app_addr;
	logic                     app_wdf_wren;
	logic                     app_wdf_end;
	logic [`KVS_BUCKET_W-1:0] app_wdf_data;
	logic [`KVS_STRB_W-1:0]   app_wdf_mask;
	logic                     out_valid;
	logic [3:0]               out_flag;
	logic [`KVS_VAL_W-1:0]    out_value;
	int                       wr_count;

	step_t steps [num_steps];
	int    exp_writes = 0;

	always #50 ui_mig_clk = ~ui_mig_clk;

	kvs_cache_top i_kvs_cache_top (
		.ui_mig_clk          (ui_mig_clk),
		.ui_mig_rst          (ui_mig_rst),
		.in_valid            (in_valid),
		.in_req              (in_req),
		.init_calib_complete (init_calib_complete),
		.app_rdy             (app_rdy),
		.app_wdf_rdy         (app_wdf_rdy),
		.app_rd_data         (app_rd_data),
		.app_rd_data_valid   (app_rd_data_valid),
		.app_en              (app_en),
		.app_cmd             (app_cmd),
		.app_addr            (app_addr),
		.app_wdf_wren        (app_wdf_wren),
		.app_wdf_end         (app_wdf_end),
		.app_wdf_data        (app_wdf_data),
		.app_wdf_mask        (app_wdf_mask),
		.out_valid           (out_valid),
		.out_flag            (out_flag),
		.out_value           (out_value)
	);

	kvs_mem_model i_kvs_mem_model (
		.ui_mig_clk          (ui_mig_clk),
		.ui_mig_rst          (ui_mig_rst),
		.app_en              (app_en),
		.app_cmd             (app_cmd),
		.app_addr            (app_addr),
		.app_wdf_wren        (app_wdf_wren),
		.app_wdf_end         (app_wdf_end),
		.app_wdf_data        (app_wdf_data),
		.app_wdf_mask        (app_wdf_mask),
		.init_calib_complete (init_calib_complete),
		.app_rdy             (app_rdy),
		.app_wdf_rdy         (app_wdf_rdy),
		.app_rd_data         (app_rd_data),
		.app_rd_data_valid   (app_rd_data_valid),
		.wr_count            (wr_count)
	);

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		abort_run();
	endtask

	task automatic report_text(input string msg);
		$display("%s", msg);
		abort_run();
	endtask

	function automatic step_t make_step(
		input logic [3:0]             op,
		input logic [`KVS_HASH_W-1:0] hash,
		input logic [`KVS_KEY_W-1:0]  key,
		input logic [`KVS_VAL_W-1:0]  value,
		input logic [3:0]             flag,
		input logic [`KVS_VAL_W-1:0]  exp_value
	);
		step_t s;
		s.req.op    = op;
		s.req.hash  = hash;
		s.req.key   = key;
		s.req.value = value;
		s.exp_flag  = flag;
		s.exp_value = exp_value;
		return s;
	endfunction

	// exactly one 16-byte group open, the other three fully masked
	function automatic bit one_slot_unmasked(input logic [`KVS_STRB_W-1:0] mask);
		int open_groups;
		int closed_groups;
		open_groups = 0;
		closed_groups = 0;
		for (int g = 0; g < `KVS_SLOTS; g++) begin
			if (mask[g*slot_bytes +: slot_bytes] == 16'h0000) begin
				open_groups++;
			end else if (mask[g*slot_bytes +: slot_bytes] == 16'hffff) begin
				closed_groups++;
			end
		end
		return (open_groups == 1) && (closed_groups == `KVS_SLOTS - 1);
	endfunction

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------
	task automatic load_steps();
		steps[0]  = make_step(`KVS_OP_GET, 32'h5a3c_0010, key_a, 32'h0, 4'h0, 32'h0);
		steps[1]  = make_step(`KVS_OP_SET, 32'h5a3c_0010, key_a, 32'h1111_2222, 4'h0, 32'h0);
		steps[2]  = make_step(`KVS_OP_GET, 32'h5a3c_0010, key_a, 32'haaaa_0001, 4'h1,
			32'h1111_2222);
		steps[3]  = make_step(`KVS_OP_GET, 32'h5a3c_0010, key_a, 32'haaaa_0002, 4'h1,
			32'haaaa_0001);
		steps[4]  = make_step(`KVS_OP_GET, 32'h5a3c_0010, key_b, 32'h0, 4'h0, 32'h0);
		steps[5]  = make_step(`KVS_OP_SET, 32'h0012_0023, key_c, 32'h0000_3333, 4'h0, 32'h0);
		steps[6]  = make_step(`KVS_OP_SET, 32'h00ab_0047, key_d, 32'h0000_4444, 4'h0, 32'h0);
		steps[7]  = make_step(`KVS_OP_GET, 32'h00ab_0047, key_d, 32'h0000_5555, 4'h1,
			32'h0000_4444);
		steps[8]  = make_step(`KVS_OP_GET, 32'h0012_0023, key_c, 32'h0000_6666, 4'h1,
			32'h0000_3333);
		steps[9]  = make_step(`KVS_OP_GET, 32'h0012_0023, key_c, 32'h0, 4'h1, 32'h0000_6666);
		steps[10] = make_step(`KVS_OP_GET, 32'h3300_0099, key_e, 32'h0, 4'h0, 32'h0);
		steps[11] = make_step(`KVS_OP_GET, 32'h00ab_0047, key_d, 32'h0, 4'h1, 32'h0000_5555);
	endtask

	task automatic check_idle();
		assert (out_valid === 1'b0) else report_value("out_valid", 32'(out_valid), 32'h0);
		assert (app_en === 1'b0) else report_value("app_en", 32'(app_en), 32'h0);
		assert (app_wdf_wren === 1'b0)
			else report_value("app_wdf_wren", 32'(app_wdf_wren), 32'h0);
	endtask

	task automatic wait_result();
		int cycles;
		cycles = 0;
		do begin
			@(posedge ui_mig_clk);
			cycles++;
			if (cycles > result_wait) begin
				report_text("timeout: out_valid never rose after a GET");
			end
		end while (!out_valid);
	endtask

	task automatic wait_writes(input int target);
		int cycles;
		cycles = 0;
		while (wr_count < target) begin
			@(posedge ui_mig_clk);
			cycles++;
			if (cycles > write_wait) begin
				report_text("timeout: the memory model never applied the expected write");
			end
		end
		assert (wr_count == target) else report_value("wr_count", wr_count, target);
	endtask

	// every write reaching the memory
	always @(posedge ui_mig_clk) begin
		if (!ui_mig_rst && app_wdf_wren && app_wdf_rdy) begin
			assert (one_slot_unmasked(app_wdf_mask)) else begin
				$display("ERROR app_wdf_mask: got 0x%h, not one open 16-byte group",
					app_wdf_mask);
				abort_run();
			end
		end
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		void'($urandom(79));
		load_steps();

		// outputs are only defined after the first reset edge
		for (int i = 0; i < 16; i++) begin
			@(posedge ui_mig_clk);
			if (i > 0) begin
				check_idle();
			end
		end
		ui_mig_rst <= 1'b0;
		repeat (4) begin
			@(posedge ui_mig_clk);
			check_idle();
		end

		for (int i = 0; i < num_steps; i++) begin
			@(posedge ui_mig_clk);
			in_req   <= steps[i].req;
			in_valid <= 1'b1;
			@(posedge ui_mig_clk);
			in_valid <= 1'b0;
			if (steps[i].req.op == `KVS_OP_SET) begin
				exp_writes++;
				wait_writes(exp_writes);
			end else begin
				wait_result();
				assert (out_flag === steps[i].exp_flag)
					else report_value("out_flag", 32'(out_flag), 32'(steps[i].exp_flag));
				assert (out_value === steps[i].exp_value)
					else report_value("out_value", out_value, steps[i].exp_value);
				// a hit writes its own value back
				if (steps[i].exp_flag == 4'h1) begin
					exp_writes++;
				end
				wait_writes(exp_writes);
			end
		end

		repeat (4) @(posedge ui_mig_clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: kvs_cache_top.f
+incdir+include
hdl/kvs_pkg.sv
hdl/kvs_sync_fifo.sv
hdl/kvs_req_intake.sv
hdl/kvs_cmd_arbiter.sv
hdl/kvs_bucket_lookup.sv
hdl/kvs_cache_top.sv
tb/kvs_mem_model.sv
tb/tb_kvs_cache_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_kvs_cache_top
FILELIST  ?= kvs_cache_top.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
